/* filelist.f */
logic/fxp_pkg.sv
logic/da_pkg.sv
logic/da_tap_shifter.sv
logic/da_lut.sv
logic/da_lut_unit.sv
logic/fxp_adder_tree.sv
logic/da_accumulator.sv
logic/da_fir.sv
test/tb_clkgen.sv
test/tb_da_fir.sv

/* logic/da_accumulator.sv */
`timescale 1ns/1ps

module da_accumulator #(
    parameter int                           N_TAPS   = 5,
    parameter int                           LUT_SIZE = 2,
    parameter fxp_pkg::coeff_t [N_TAPS-1:0] COEFFS   = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  da_pkg::da_sum_t sum,
    output fxp_pkg::acc_t   y,
    output logic            y_stb
);
    import fxp_pkg::*;
    import da_pkg::*;

    // Sum over tables of minus the all-zero-address entry
    function automatic acc_t calc_offset();
        acc_t  off;
        csum_t s;
        off = '0;
        for (int t = 0; t < N_TAPS; t += LUT_SIZE) begin
            s = '0;
            // Same grouping and rounding as the tables
            for (int k = t; k < t + LUT_SIZE && k < N_TAPS; k++) begin
                s -= csum_t'(coeff_t'(COEFFS[k]));
            end
            off -= acc_t'(round_fxp(s));
        end
        return off;
    endfunction

    localparam acc_t OFFSET = calc_offset();

    acc_t acc;
    acc_t acc_next;
    acc_t value_ext;

    // Horner step, sign plane has negative weight
    always_comb begin
        value_ext = acc_t'(sum.value);
        if (sum.first) begin
            acc_next = -value_ext;
        end else begin
            acc_next = (acc <<< 1) + value_ext;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc   <= '0;
            y_stb <= 1'b0;
        end else begin
            if (sum.valid) begin
                acc <= acc_next;
            end
            y_stb <= sum.valid && sum.last;
        end
    end

    // Offset binary back to two's complement
    always_ff @(posedge clk) begin
        if (sum.valid && sum.last) begin
            y <= (acc_next - OFFSET) >>> 1;
        end
    end

    // Tags on an idle cycle point at a broken tag pipeline
    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        sum.last |-> sum.valid);

endmodule

/* logic/da_fir.sv */
`timescale 1ns/1ps

module da_fir #(
    parameter int                           N_TAPS   = 5,
    parameter int                           SAMPLE_W = 8,
    parameter int                           LUT_SIZE = 2,
    // Element j is the coefficient of tap j
    parameter fxp_pkg::coeff_t [N_TAPS-1:0] COEFFS   = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic signed [SAMPLE_W-1:0] sample,
    input  logic                       sample_stb,
    output logic                       busy,
    output fxp_pkg::acc_t              y,
    output logic                       y_stb
);
    import da_pkg::*;

    logic [N_TAPS-1:0] plane;
    logic              plane_valid;
    da_tag_t           plane_tag;
    da_sum_t           sum;

    // Producer, bit planes sign first
    da_tap_shifter #(
        .N_TAPS   (N_TAPS),
        .SAMPLE_W (SAMPLE_W)
    ) u_shifter (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample      (sample),
        .sample_stb  (sample_stb),
        .busy        (busy),
        .plane       (plane),
        .plane_valid (plane_valid),
        .plane_tag   (plane_tag)
    );

    // Table lookup and adder tree
    da_lut_unit #(
        .N_TAPS   (N_TAPS),
        .SAMPLE_W (SAMPLE_W),
        .LUT_SIZE (LUT_SIZE),
        .COEFFS   (COEFFS)
    ) u_lut_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .plane       (plane),
        .plane_valid (plane_valid),
        .plane_tag   (plane_tag),
        .sum         (sum)
    );

    // Consumer
    da_accumulator #(
        .N_TAPS   (N_TAPS),
        .LUT_SIZE (LUT_SIZE),
        .COEFFS   (COEFFS)
    ) u_acc (
        .clk   (clk),
        .rst_n (rst_n),
        .sum   (sum),
        .y     (y),
        .y_stb (y_stb)
    );

endmodule

/* logic/da_lut.sv */
`timescale 1ns/1ps

module da_lut #(
    parameter int                         SIZE = 2,
    parameter fxp_pkg::coeff_t [SIZE-1:0] FACT = '0
) (
    input  logic [SIZE-1:0] sel,
    output fxp_pkg::fxp_t   entry
);
    import fxp_pkg::*;
    import da_pkg::*;

    localparam int DEPTH = 2 ** SIZE;

    typedef fxp_t table_t [DEPTH];

    // Entry a = sum of +FACT[j] where a[j] is 1, -FACT[j] where 0
    function automatic table_t build_table();
        table_t tbl;
        csum_t  acc;
        for (int a = 0; a < DEPTH; a++) begin
            acc = '0;
            for (int j = 0; j < SIZE; j++) begin
                if (a[j]) begin
                    acc += csum_t'(coeff_t'(FACT[j]));
                end else begin
                    acc -= csum_t'(coeff_t'(FACT[j]));
                end
            end
            // One rounding per entry, not per coefficient
            tbl[a] = round_fxp(acc);
        end
        return tbl;
    endfunction

    // Fixed at elaboration
    localparam table_t TABLE = build_table();

    // Plain ROM read
    assign entry = TABLE[sel];

endmodule

/* logic/da_lut_unit.sv */
`timescale 1ns/1ps

module da_lut_unit #(
    parameter int                           N_TAPS   = 5,
    parameter int                           SAMPLE_W = 8,
    parameter int                           LUT_SIZE = 2,
    parameter fxp_pkg::coeff_t [N_TAPS-1:0] COEFFS   = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [N_TAPS-1:0] plane,
    input  logic              plane_valid,
    input  da_pkg::da_tag_t   plane_tag,
    output da_pkg::da_sum_t   sum
);
    import fxp_pkg::*;
    import da_pkg::*;

    // Full tables, then one smaller table for leftover taps
    localparam int N_FULL  = N_TAPS / LUT_SIZE;
    localparam int REST    = N_TAPS % LUT_SIZE;
    localparam int N_LUTS  = N_FULL + ((REST > 0) ? 1 : 0);

    // Table register plus one per tree level
    localparam int LUT_LAT = 1 + $clog2(N_LUTS);

    fxp_t               lut_q [N_LUTS];
    fxp_t               tree_out;
    da_tag_t            tag_dly [LUT_LAT];
    logic [LUT_LAT-1:0] valid_dly;

    for (genvar i = 0; i < N_LUTS; i++) begin : g_lut
        localparam int BASE = i * LUT_SIZE;
        // Last table shrinks to the remainder
        localparam int SZ   = (i < N_FULL) ? LUT_SIZE : REST;

        fxp_t entry;

        // Table i sees taps BASE..BASE+SZ-1 and their coefficients
        da_lut #(
            .SIZE (SZ),
            .FACT (COEFFS[BASE +: SZ])
        ) u_lut (
            .sel   (plane[BASE +: SZ]),
            .entry (entry)
        );

        always_ff @(posedge clk) begin
            lut_q[i] <= entry;
        end
    end

    fxp_adder_tree #(
        .N_IN (N_LUTS)
    ) u_tree (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_vec (lut_q),
        .out    (tree_out)
    );

    // Tags and valid ride beside the data, same depth as table plus tree
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < LUT_LAT; k++) begin
                tag_dly[k] <= '0;
            end
            valid_dly <= '0;
        end else begin
            tag_dly[0]   <= plane_tag;
            valid_dly[0] <= plane_valid;
            for (int k = 1; k < LUT_LAT; k++) begin
                tag_dly[k]   <= tag_dly[k-1];
                valid_dly[k] <= valid_dly[k-1];
            end
        end
    end

    always_comb begin
        sum.value = tree_out;
        sum.first = tag_dly[LUT_LAT-1].first;
        sum.last  = tag_dly[LUT_LAT-1].last;
        sum.valid = valid_dly[LUT_LAT-1];
    end

    // Sign and LSB plane coincide only for one-bit samples
    a_tag_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(sum.first && sum.last) || SAMPLE_W == 1);

endmodule

/* logic/da_pkg.sv */
package da_pkg;

    import fxp_pkg::*;

    // Shift from coefficient scaling down to one bit below fxp_t LSB
    localparam int ROUND_SHIFT = COEFF_BIAS - N_MANT - 1;

    // Room for a sum of many 64-bit coefficients
    localparam int CSUM_W = 80;

    typedef logic signed [CSUM_W-1:0] csum_t;

    // Position of a bit plane within its sample
    typedef struct packed {
        logic first;    // sign plane
        logic last;     // LSB plane
    } da_tag_t;

    // Tree output plus the tags that travelled beside it
    typedef struct packed {
        fxp_t value;
        logic first;
        logic last;
        logic valid;
    } da_sum_t;

    // Coefficient-scaled sum to fxp_t, round half up
    function automatic fxp_t round_fxp(csum_t sum);
        csum_t tmp;
        // Keep one guard bit, add half an LSB
        tmp = (sum >>> ROUND_SHIFT) + 1;
        // Drop the guard bit
        tmp = tmp >>> 1;
        return fxp_t'(tmp);
    endfunction

endpackage

/* logic/da_tap_shifter.sv */
`timescale 1ns/1ps

module da_tap_shifter #(
    parameter int N_TAPS   = 5,
    parameter int SAMPLE_W = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic signed [SAMPLE_W-1:0] sample,
    input  logic                       sample_stb,
    output logic                       busy,
    output logic [N_TAPS-1:0]          plane,
    output logic                       plane_valid,
    output da_pkg::da_tag_t            plane_tag
);
    import da_pkg::*;

    localparam int               BIT_W   = (SAMPLE_W > 1) ? $clog2(SAMPLE_W) : 1;
    localparam logic [BIT_W-1:0] MSB_IDX = BIT_W'(SAMPLE_W - 1);

    // Tap 0 holds the newest sample
    logic signed [SAMPLE_W-1:0] taps [N_TAPS];

    // Bit index of the next plane to send
    logic [BIT_W-1:0] bit_idx;
    logic             active;
    logic             accept;
    logic [N_TAPS-1:0] column;
    da_tag_t           tag_next;

    // Free once the LSB plane is next, so the following strobe can overlap it
    assign busy   = active && (bit_idx != '0);
    assign accept = sample_stb && !busy;

    // One bit of every tap at the current index
    always_comb begin
        for (int j = 0; j < N_TAPS; j++) begin
            column[j] = taps[j][bit_idx];
        end
        tag_next.first = (bit_idx == MSB_IDX);
        tag_next.last  = (bit_idx == '0);
    end

    // Delay line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < N_TAPS; j++) begin
                taps[j] <= '0;
            end
        end else if (accept) begin
            taps[0] <= sample;
            for (int j = 1; j < N_TAPS; j++) begin
                taps[j] <= taps[j-1];
            end
        end
    end

    // Plane counter, MSB down to LSB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            bit_idx     <= '0;
            plane_valid <= 1'b0;
            plane_tag   <= '0;
        end else begin
            plane_valid <= active;
            plane_tag   <= active ? tag_next : '0;
            if (active && bit_idx == '0) begin
                active <= 1'b0;
            end else if (active) begin
                bit_idx <= bit_idx - 1'b1;
            end
            // New sample restarts at the sign plane, even on the LSB cycle
            if (accept) begin
                active  <= 1'b1;
                bit_idx <= MSB_IDX;
            end
        end
    end

    // Column reads the taps before this edge's shift
    always_ff @(posedge clk) begin
        if (active) begin
            plane <= column;
        end
    end

    // LSB plane always closes a run that began with the sign plane
    if (SAMPLE_W > 1) begin : g_run_chk
        a_plane_run: assert property (@(posedge clk) disable iff (!rst_n)
            plane_valid && plane_tag.last |->
                $past(plane_valid && plane_tag.first, SAMPLE_W - 1));
    end

endmodule

/* logic/fxp_adder_tree.sv */
`timescale 1ns/1ps

module fxp_adder_tree #(
    parameter int N_IN = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    input  fxp_pkg::fxp_t in_vec [N_IN],
    output fxp_pkg::fxp_t out
);
    import fxp_pkg::*;

    localparam int LEVELS   = $clog2(N_IN);
    // At least one row so the array stays legal with a single input
    localparam int REG_ROWS = (LEVELS > 0) ? LEVELS : 1;

    // Live operands at a given level
    function automatic int level_cnt(int lvl);
        int n;
        n = N_IN;
        for (int l = 0; l < lvl; l++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    // Row 0 is the input vector, row l the output of register row l-1
    fxp_t node  [LEVELS+1][N_IN];
    fxp_t lvl_q [REG_ROWS][N_IN];

    always_comb begin
        node[0] = in_vec;
        for (int l = 1; l <= LEVELS; l++) begin
            node[l] = lvl_q[l-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < REG_ROWS; l++) begin
                for (int k = 0; k < N_IN; k++) begin
                    lvl_q[l][k] <= '0;
                end
            end
        end else begin
            for (int l = 0; l < LEVELS; l++) begin
                // Unused slots hold zero
                for (int k = 0; k < N_IN; k++) begin
                    lvl_q[l][k] <= '0;
                end
                // Neighbouring pairs
                for (int k = 0; k < N_IN / 2; k++) begin
                    if (2 * k + 1 < level_cnt(l)) begin
                        lvl_q[l][k] <= node[l][2*k] + node[l][2*k+1];
                    end
                end
                // Odd one out moves up unchanged
                if (level_cnt(l) % 2 == 1) begin
                    lvl_q[l][level_cnt(l)/2] <= node[l][level_cnt(l)-1];
                end
            end
        end
    end

    // Zero levels leaves the single input combinational
    assign out = node[LEVELS][0];

endmodule

/* logic/fxp_pkg.sv */
package fxp_pkg;

    // Integer and fraction bits of table and tree words
    localparam int N_INT  = 8;
    localparam int N_MANT = 23;

    // Sign bit on top of integer and fraction
    localparam int FXP_W = N_INT + N_MANT + 1;

    // Coefficients carry 32 fraction bits
    localparam int COEFF_BIAS = 32;
    localparam int COEFF_W    = 64;

    // Horner accumulator, wide enough for B-bit sample growth
    localparam int ACC_W = 48;

    // Table entries and adder tree values
    typedef logic signed [FXP_W-1:0] fxp_t;

    // One filter coefficient
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // Accumulator and filter output, same scaling as fxp_t
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_da_fir \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_da_fir > sim.log 2>&1
cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1

/* test/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Low from time zero, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* test/tb_da_fir.sv */
`timescale 1ns/1ps

module tb_da_fir;
    import fxp_pkg::*;

    localparam int TAPS     = 5;
    localparam int SAMPLE_W = 8;
    localparam int LUT_SIZE = 2;
    // Table register plus tree levels, then the output register
    localparam int LUT_LAT  = 1 + $clog2((TAPS + LUT_SIZE - 1) / LUT_SIZE);
    localparam int LATENCY  = SAMPLE_W + LUT_LAT + 1;
    localparam int TIMEOUT  = 4 * LATENCY;

    localparam logic signed [SAMPLE_W-1:0] S_MIN = {1'b1, {(SAMPLE_W - 1){1'b0}}};
    localparam logic signed [SAMPLE_W-1:0] S_MAX = ~S_MIN;

    typedef coeff_t [TAPS-1:0] coeff_vec_t;

    // Coefficients counted in fxp_t LSBs
    function automatic longint coeff_q(int j);
        case (j)
            0:       return 64'sd12345678;
            1:       return -64'sd3456789;
            2:       return 64'sd8388608;
            3:       return 64'sd2097151;
            4:       return -64'sd5000000;
            default: return 64'sd0;
        endcase
    endfunction

    // Scaled up to coefficient format with low bits zero so rounding is exact
    function automatic coeff_vec_t make_coeffs();
        coeff_vec_t v;
        for (int j = 0; j < TAPS; j++) begin
            v[j] = coeff_t'(coeff_q(j)) <<< (COEFF_BIAS - N_MANT);
        end
        return v;
    endfunction

    localparam coeff_vec_t COEFFS = make_coeffs();

    logic                       clk;
    logic                       rst_n;
    logic signed [SAMPLE_W-1:0] sample;
    logic                       sample_stb;
    logic                       busy;
    acc_t                       y;
    logic                       y_stb;

    int   errors;
    int   timeouts;
    int   cycle = 0;
    // Reference delay line with tap 0 newest
    int   model_taps [TAPS];
    acc_t exp_y [$];
    int   exp_cyc [$];
    acc_t got_y [$];
    int   got_cyc [$];

    tb_clkgen #(.PERIOD(20), .RESET_CYCLES(8)) u_clkgen (.clk(clk), .rst_n(rst_n));

    da_fir #(
        .N_TAPS   (TAPS),
        .SAMPLE_W (SAMPLE_W),
        .LUT_SIZE (LUT_SIZE),
        .COEFFS   (COEFFS)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .sample_stb (sample_stb),
        .busy       (busy),
        .y          (y),
        .y_stb      (y_stb)
    );

    // Output monitor logs a strobe that rose on the previous edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (y_stb === 1'b1) begin
            got_y.push_back(y);
            got_cyc.push_back(cycle - 1);
        end
    end

    task automatic check_y(string name, acc_t expected, acc_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_busy(string name, logic expected, logic actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_cycles(string name, int expected, int actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %0d cycles, actual %0d", name, expected, actual);
        end
    endtask

    // Accepted sample shifts in and y sums rounded coefficient times tap
    task automatic model_push(logic signed [SAMPLE_W-1:0] value, int acc_cycle);
        acc_t s;
        for (int j = TAPS - 1; j > 0; j--) begin
            model_taps[j] = model_taps[j-1];
        end
        model_taps[0] = int'(value);
        s = '0;
        for (int j = 0; j < TAPS; j++) begin
            s += acc_t'(coeff_q(j)) * acc_t'(model_taps[j]);
        end
        exp_y.push_back(s);
        exp_cyc.push_back(acc_cycle + LATENCY);
    endtask

    // Strobe stays high until the shifter is free
    task automatic drive_strobe(logic signed [SAMPLE_W-1:0] value, output int acc_cycle);
        int n;
        n = 0;
        acc_cycle = -1;
        @(posedge clk);
        sample     <= value;
        sample_stb <= 1'b1;
        while (acc_cycle < 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            if (!busy) begin
                acc_cycle = cycle;
            end
        end
        sample_stb <= 1'b0;
        if (acc_cycle < 0) begin
            timeouts++;
            $display("Timeout: sample %0d was never accepted, busy stuck high", value);
        end else begin
            model_push(value, acc_cycle);
        end
    endtask

    // Oldest output against the model and its latency
    task automatic collect_result(string name, output acc_t actual, output int out_cycle);
        int n;
        n = 0;
        actual = 'x;
        out_cycle = -1;
        while (got_y.size() == 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (got_y.size() == 0) begin
            timeouts++;
            $display("Timeout: no output strobe arrived for %s", name);
        end else begin
            actual    = got_y.pop_front();
            out_cycle = got_cyc.pop_front();
            check_y(name, exp_y.pop_front(), actual);
            // Measured latency is output cycle minus accept cycle
            check_cycles({name, " latency"}, LATENCY,
                out_cycle - exp_cyc.pop_front() + LATENCY);
        end
    endtask

    task automatic send_one(string name, logic signed [SAMPLE_W-1:0] value,
        output acc_t actual);
        int c;
        int o;
        drive_strobe(value, c);
        collect_result(name, actual, o);
    endtask

    // Nothing may come out once all expected results are in
    task automatic expect_quiet(string name);
        repeat (LATENCY + 2) @(posedge clk);
        if (got_y.size() != 0) begin
            errors++;
            $display("%s: %0d output strobes that no sample explains", name, got_y.size());
            got_y.delete();
            got_cyc.delete();
        end
    endtask

    task automatic reset_impulse();
        acc_t a;
        int   n;
        n = 0;
        while (rst_n !== 1'b1 && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        @(posedge clk);
        check_busy("reset busy", 1'b0, busy);
        check_busy("reset y_stb", 1'b0, y_stb);
        send_one("reset impulse", SAMPLE_W'(1), a);
        check_y("reset impulse coeff 0", acc_t'(coeff_q(0)), a);
    endtask

    // Flush with zeros and then expect one coefficient per output
    task automatic impulse_response();
        acc_t a;
        for (int k = 0; k < TAPS; k++) begin
            send_one("impulse flush", SAMPLE_W'(0), a);
        end
        for (int k = 0; k < TAPS; k++) begin
            send_one("impulse", (k == 0) ? SAMPLE_W'(1) : SAMPLE_W'(0), a);
            check_y($sformatf("impulse coeff %0d", k), acc_t'(coeff_q(k)), a);
        end
    endtask

    task automatic extreme_samples();
        acc_t a;
        for (int k = 0; k < 2 * TAPS; k++) begin
            send_one($sformatf("extreme %0d", k), (k % 3 == 0) ? S_MAX : S_MIN, a);
        end
    endtask

    // Second strobe held through busy and taken in the first free cycle
    task automatic back_to_back();
        acc_t a;
        int   c0;
        int   c1;
        int   o0;
        int   o1;
        drive_strobe(SAMPLE_W'(100), c0);
        drive_strobe(SAMPLE_W'(-77), c1);
        check_cycles("back-to-back accept spacing", SAMPLE_W, c1 - c0);
        collect_result("back-to-back first", a, o0);
        collect_result("back-to-back second", a, o1);
        check_cycles("back-to-back output spacing", SAMPLE_W, o1 - o0);
    endtask

    task automatic ignored_strobes();
        acc_t a;
        int   c;
        int   o;
        drive_strobe(SAMPLE_W'(55), c);
        @(posedge clk);
        sample     <= SAMPLE_W'(-99);
        sample_stb <= 1'b1;
        @(posedge clk);
        check_busy("ignored strobe busy", 1'b1, busy);
        sample_stb <= 1'b0;
        @(posedge clk);
        check_busy("busy after ignored strobe", 1'b1, busy);
        drive_strobe(SAMPLE_W'(-33), c);
        collect_result("ignored first", a, o);
        collect_result("ignored second", a, o);
        expect_quiet("ignored strobes");
    endtask

    task automatic random_stream();
        acc_t                       a;
        int                         c;
        int                         o;
        logic signed [SAMPLE_W-1:0] v;
        for (int k = 0; k < 40; k++) begin
            repeat (SAMPLE_W - 2 + $urandom % 6) @(posedge clk);
            v = SAMPLE_W'($urandom);
            drive_strobe(v, c);
        end
        for (int k = 0; k < 40; k++) begin
            collect_result($sformatf("random %0d", k), a, o);
        end
    endtask

    initial begin
        void'($urandom(32'h9b68));
        sample     = '0;
        sample_stb = 1'b0;
        errors     = 0;
        timeouts   = 0;
        for (int j = 0; j < TAPS; j++) begin
            model_taps[j] = 0;
        end
        reset_impulse();
        impulse_response();
        extreme_samples();
        back_to_back();
        ignored_strobes();
        random_stream();
        expect_quiet("end of run");
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
